/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cdc_frame_bridge -f tb.f -o sim_tb \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Verilator build or run failed"; exit 1; }
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

/* tb.f */
verilog/cdc_pkg.sv
verilog/gray_send.sv
verilog/ram_2port.sv
verilog/fifo_2clock.sv
verilog/apb_push_port.sv
verilog/frame_sum_stage.sv
verilog/cdc_frame_bridge.sv
testbench/tb_cdc_frame_bridge.sv

/* testbench/tb_cdc_frame_bridge.sv */
`timescale 1ns/1ps

module tb_cdc_frame_bridge;

   localparam int AWIDTH = 4;
   // Usable FIFO entries plus the one word parked in the output register
   localparam int CAP = (2**AWIDTH - 1) + 1;
   localparam logic [31:0] SEED = 32'h26e1;
   localparam logic [3:0] ADDR_MID = 4'h0;
   localparam logic [3:0] ADDR_LAST = 4'h4;
   localparam logic [3:0] ADDR_STATUS = 4'h8;
   localparam int ROWS = 6;

   typedef struct packed {
      int   len;
      int   seed_ofs;
      logic hold;
   } row_t;

   typedef struct packed {
      logic        is_last;
      logic [31:0] data;
   } exp_word_t;

   // Frame length, seed offset, sink held low while the frame is pushed
   row_t stim [ROWS] = '{
      '{1, 1, 1'b0},
      '{5, 2, 1'b0},
      '{12, 3, 1'b0},
      '{7, 4, 1'b1},
      '{CAP, 5, 1'b1},
      '{9, 6, 1'b0}
   };

   logic        wclk = 1'b0;
   logic        rclk = 1'b0;
   logic        arst = 1'b1;
   logic        psel_i = 1'b0;
   logic        penable_i = 1'b0;
   logic        pwrite_i = 1'b0;
   logic [3:0]  paddr_i = 4'h0;
   logic [31:0] pwdata_i = 32'h0;
   logic [31:0] prdata_o;
   logic        pready_o;
   logic        pslverr_o;
   logic        out_valid_o;
   logic [31:0] out_data_o;
   logic        out_last_o;
   logic [31:0] out_sum_o;
   logic        out_ready_i = 1'b0;

   int          driver_errs = 0;
   int          sink_errs = 0;
   int          cycles = 0;
   int          cycle_limit;
   // 0 holds ready low, 1 holds it high, 2 toggles it randomly
   logic [1:0]  sink_mode = 2'd0;
   logic [31:0] ready_state = SEED;
   logic [31:0] sum_acc = 32'h0;
   logic        held = 1'b0;
   exp_word_t   held_word;
   exp_word_t   exp_q [$];

   cdc_frame_bridge #(
      .AWIDTH(AWIDTH)
   ) u_cdc_frame_bridge (
      .wclk        (wclk),
      .rclk        (rclk),
      .arst        (arst),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .pslverr_o   (pslverr_o),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o),
      .out_last_o  (out_last_o),
      .out_sum_o   (out_sum_o),
      .out_ready_i (out_ready_i)
   );

   always #10 rclk = ~rclk;
   always #7 wclk = ~wclk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic driver_error(input string name, input logic [31:0] want,
                               input logic [31:0] got);
      $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, want, got);
      driver_errs++;
   endtask

   task automatic sink_error(input string name, input logic [31:0] want,
                             input logic [31:0] got);
      $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, want, got);
      sink_errs++;
   endtask

   // One APB transfer through setup and access phases
   // Responses are sampled in the middle of the access phase
   task automatic apb_transfer(input logic write, input logic [3:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      @(negedge wclk);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = write;
      paddr_i   = addr;
      pwdata_i  = wdata;
      @(negedge wclk);
      penable_i = 1'b1;
      #2;
      assert (pready_o === 1'b1) else driver_error("pready_o", 32'd1, 32'(pready_o));
      rdata = prdata_o;
      err   = pslverr_o;
      @(negedge wclk);
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   // Sink sets ready on the falling edge, then checks the settled handshake
   always @(negedge rclk) begin
      exp_word_t want;
      if (sink_mode == 2'd2) begin
         ready_state = xorshift(ready_state);
         out_ready_i = ready_state[4];
      end else begin
         out_ready_i = (sink_mode == 2'd1);
      end
      #1;
      if (arst === 1'b0) begin
         if (held) begin
            assert (out_valid_o === 1'b1) else begin
               $display("At %0d ns out_valid_o dropped before its beat was taken", $time);
               sink_errs++;
            end
            assert (out_data_o === held_word.data) else
               sink_error("out_data_o", held_word.data, out_data_o);
            assert (out_last_o === held_word.is_last) else
               sink_error("out_last_o", 32'(held_word.is_last), 32'(out_last_o));
         end
         held      = out_valid_o & ~out_ready_i;
         held_word = '{is_last: out_last_o, data: out_data_o};
         if (out_valid_o === 1'b1 && out_ready_i === 1'b1) begin
            if (exp_q.size() == 0) begin
               $display("At %0d ns a beat came out with no word left to expect", $time);
               sink_errs++;
            end else begin
               want = exp_q.pop_front();
               assert (out_data_o === want.data) else
                  sink_error("out_data_o", want.data, out_data_o);
               assert (out_last_o === want.is_last) else
                  sink_error("out_last_o", 32'(want.is_last), 32'(out_last_o));
               if (want.is_last) begin
                  assert (out_sum_o === (sum_acc ^ want.data)) else
                     sink_error("out_sum_o", sum_acc ^ want.data, out_sum_o);
                  sum_acc = 32'h0;
               end else begin
                  sum_acc = sum_acc ^ want.data;
               end
            end
         end
      end
   end

   // Watchdog on rclk cycles
   always @(posedge rclk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Run stopped after %0d rclk cycles without finishing", cycle_limit);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      logic [31:0] word;
      logic [31:0] rdata;
      logic [31:0] want_status;
      logic        err;
      logic        ends;
      int          total;
      total = 0;
      for (int r = 0; r < ROWS; r++) begin
         total += stim[r].len;
      end
      cycle_limit = 40 * total + 500;
      repeat (8) @(posedge rclk);
      @(negedge rclk);
      arst = 1'b0;

      // Quiet state out of reset
      assert (out_valid_o === 1'b0) else driver_error("out_valid_o", 32'd0, 32'(out_valid_o));
      assert (pslverr_o === 1'b0) else driver_error("pslverr_o", 32'd0, 32'(pslverr_o));
      apb_transfer(1'b0, ADDR_STATUS, 32'h0, rdata, err);
      assert (rdata === 32'h0) else driver_error("prdata_o", 32'h0, rdata);

      for (int r = 0; r < ROWS; r++) begin
         sink_mode = stim[r].hold ? 2'd0 : 2'd2;
         word = SEED + stim[r].seed_ofs;
         for (int i = 0; i < stim[r].len; i++) begin
            word = xorshift(word);
            ends = (i == stim[r].len - 1);
            exp_q.push_back('{is_last: ends, data: word});
            apb_transfer(1'b1, ends ? ADDR_LAST : ADDR_MID, word, rdata, err);
            assert (err === 1'b0) else begin
               driver_error("pslverr_o", 32'd0, 32'(err));
               void'(exp_q.pop_back());
            end
         end
         if (stim[r].hold) begin
            // Pointers settle after a few idle cycles of the slower clock
            repeat (10) @(posedge rclk);
            want_status = stim[r].len - 1;
            want_status[31] = (stim[r].len == CAP);
            apb_transfer(1'b0, ADDR_STATUS, 32'h0, rdata, err);
            assert (rdata === want_status) else driver_error("prdata_o", want_status, rdata);
            if (stim[r].len == CAP) begin
               apb_transfer(1'b1, ADDR_MID, xorshift(word), rdata, err);
               assert (err === 1'b1) else driver_error("pslverr_o", 32'd1, 32'(err));
            end
            sink_mode = 2'd2;
         end
         while (exp_q.size() != 0) begin
            @(posedge rclk);
         end
      end

      // Stray or repeated beats would show up here
      sink_mode = 2'd1;
      repeat (20) @(posedge rclk);
      $display("Errors on driver side: %0d, errors on sink side: %0d", driver_errs, sink_errs);
      if (driver_errs == 0 && sink_errs == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* verilog/apb_push_port.sv */
`timescale 1ns/1ps

module apb_push_port #(
   parameter int AWIDTH = 9
) (
   input  logic                        wclk,
   input  logic                        arst,
   input  logic                        psel_i,
   input  logic                        penable_i,
   input  logic                        pwrite_i,
   input  logic [3:0]                  paddr_i,
   input  logic [cdc_pkg::DATA_W-1:0]  pwdata_i,
   output logic [cdc_pkg::DATA_W-1:0]  prdata_o,
   output logic                        pready_o,
   output logic                        pslverr_o,
   output cdc_pkg::fifo_word_t         wr_word_o,
   output logic                        wr_valid_o,
   input  logic                        wr_ready_i,
   input  logic [AWIDTH-1:0]           level_i
);

   import cdc_pkg::*;

   reg_op_e           op;
   logic              access;
   logic              push;
   logic [DATA_W-1:0] status;

   always_comb begin
      case (paddr_i)
         REG_PUSH_MID:  op = OP_PUSH_MID;
         REG_PUSH_LAST: op = OP_PUSH_LAST;
         REG_STATUS:    op = OP_STATUS;
         default:       op = OP_NONE;
      endcase
   end

   // No wait states
   assign access   = psel_i & penable_i;
   assign pready_o = access;

   // Push is offered to the FIFO for the access cycle only
   assign push       = access & pwrite_i & (op == OP_PUSH_MID || op == OP_PUSH_LAST);
   assign wr_valid_o = push;
   assign wr_word_o  = '{last: (op == OP_PUSH_LAST), data: pwdata_i};

   // A refused push drops its word
   assign pslverr_o = push & ~wr_ready_i;

   // Status word from the live full flag and fill level
   always_comb begin
      status                  = '0;
      status[STATUS_FULL_BIT] = ~wr_ready_i;
      status[AWIDTH-1:0]      = level_i;
   end

   assign prdata_o = (access && !pwrite_i && op == OP_STATUS) ? status : '0;

endmodule

/* verilog/cdc_frame_bridge.sv */
`timescale 1ns/1ps

module cdc_frame_bridge #(
   parameter int AWIDTH = 9
) (
   input  logic                       wclk,
   input  logic                       rclk,
   input  logic                       arst,
   input  logic                       psel_i,
   input  logic                       penable_i,
   input  logic                       pwrite_i,
   input  logic [3:0]                 paddr_i,
   input  logic [cdc_pkg::DATA_W-1:0] pwdata_i,
   output logic [cdc_pkg::DATA_W-1:0] prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o,
   output logic                       out_valid_o,
   output logic [cdc_pkg::DATA_W-1:0] out_data_o,
   output logic                       out_last_o,
   output logic [cdc_pkg::DATA_W-1:0] out_sum_o,
   input  logic                       out_ready_i
);

   import cdc_pkg::*;

   fifo_word_t        wr_word;
   logic              wr_valid;
   logic              wr_ready;
   logic [AWIDTH-1:0] level_wclk;
   fifo_word_t        rd_word;
   logic              rd_valid;
   logic              rd_ready;

   // Write domain
   apb_push_port #(
      .AWIDTH(AWIDTH)
   ) u_apb_push_port (
      .wclk       (wclk),
      .arst       (arst),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .wr_word_o  (wr_word),
      .wr_valid_o (wr_valid),
      .wr_ready_i (wr_ready),
      .level_i    (level_wclk)
   );

   // Domain crossing
   fifo_2clock #(
      .AWIDTH(AWIDTH)
   ) u_fifo_2clock (
      .wclk         (wclk),
      .arst         (arst),
      .wr_word_i    (wr_word),
      .wr_valid_i   (wr_valid),
      .wr_ready_o   (wr_ready),
      .level_wclk_o (level_wclk),
      .rclk         (rclk),
      .rd_word_o    (rd_word),
      .rd_valid_o   (rd_valid),
      .rd_ready_i   (rd_ready),
      .level_rclk_o ()
   );

   // Read domain
   frame_sum_stage u_frame_sum_stage (
      .rclk        (rclk),
      .arst        (arst),
      .rd_word_i   (rd_word),
      .rd_valid_i  (rd_valid),
      .rd_ready_o  (rd_ready),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o),
      .out_last_o  (out_last_o),
      .out_sum_o   (out_sum_o),
      .out_ready_i (out_ready_i)
   );

endmodule

/* verilog/cdc_pkg.sv */
package cdc_pkg;

   // Width of one payload word
   localparam int DATA_W = 32;

   // One FIFO entry, a payload word plus its end-of-frame marker
   typedef struct packed {
      logic              last;
      logic [DATA_W-1:0] data;
   } fifo_word_t;

   // Register access decoded from the APB address
   typedef enum logic [1:0] {
      OP_NONE      = 2'd0,
      OP_PUSH_MID  = 2'd1,
      OP_PUSH_LAST = 2'd2,
      OP_STATUS    = 2'd3
   } reg_op_e;

   // Register offsets
   localparam logic [3:0] REG_PUSH_MID  = 4'h0;
   localparam logic [3:0] REG_PUSH_LAST = 4'h4;
   localparam logic [3:0] REG_STATUS    = 4'h8;

   // Status word layout, level sits in the low bits
   localparam int STATUS_FULL_BIT = 31;

endpackage

/* verilog/fifo_2clock.sv */
`timescale 1ns/1ps

module fifo_2clock #(
   parameter int AWIDTH = 9
) (
   input  logic                wclk,
   input  logic                arst,
   input  cdc_pkg::fifo_word_t wr_word_i,
   input  logic                wr_valid_i,
   output logic                wr_ready_o,
   output logic [AWIDTH-1:0]   level_wclk_o,
   input  logic                rclk,
   output cdc_pkg::fifo_word_t rd_word_o,
   output logic                rd_valid_o,
   input  logic                rd_ready_i,
   output logic [AWIDTH-1:0]   level_rclk_o
);

   logic [AWIDTH-1:0] wr_addr;
   logic [AWIDTH-1:0] next_wr_addr;
   logic [AWIDTH-1:0] rd_addr_wclk;
   logic [AWIDTH-1:0] rd_addr;
   logic [AWIDTH-1:0] next_rd_addr;
   logic [AWIDTH-1:0] wr_addr_rclk;
   logic              full;
   logic              write;
   logic              read;
   logic              data_valid;
   logic              ram_re;

   // Write side
   assign next_wr_addr = wr_addr + 1'b1;
   assign full         = (next_wr_addr == rd_addr_wclk);
   assign wr_ready_o   = ~full;
   assign write        = wr_valid_i & ~full;

   always_ff @(posedge wclk or posedge arst) begin
      if (arst) begin
         wr_addr <= '0;
      end else if (write) begin
         wr_addr <= next_wr_addr;
      end
   end

   ram_2port #(
      .AWIDTH(AWIDTH)
   ) u_ram (
      .wclk    (wclk),
      .we_i    (write),
      .waddr_i (wr_addr),
      .wdata_i (wr_word_i),
      .rclk    (rclk),
      .re_i    (ram_re),
      .raddr_i (next_rd_addr),
      .rdata_o (rd_word_o)
   );

   // Read side, RAM output register holds the head word when data_valid is set
   assign rd_valid_o   = data_valid;
   assign read         = data_valid & rd_ready_i;
   assign next_rd_addr = rd_addr + {{(AWIDTH-1){1'b0}}, data_valid};
   assign ram_re       = read | ~data_valid;

   always_ff @(posedge rclk or posedge arst) begin
      if (arst) begin
         rd_addr    <= '0;
         data_valid <= 1'b0;
      end else begin
         if (read) begin
            rd_addr <= rd_addr + 1'b1;
         end
         if (read && next_rd_addr == wr_addr_rclk) begin
            data_valid <= 1'b0;
         end else if (next_rd_addr != wr_addr_rclk) begin
            data_valid <= 1'b1;
         end
      end
   end

   gray_send #(.WIDTH(AWIDTH)) u_send_wr_addr (
      .clk_in_i  (wclk),
      .addr_i    (wr_addr),
      .clk_out_i (rclk),
      .arst      (arst),
      .addr_o    (wr_addr_rclk)
   );

   gray_send #(.WIDTH(AWIDTH)) u_send_rd_addr (
      .clk_in_i  (rclk),
      .addr_i    (rd_addr),
      .clk_out_i (wclk),
      .arst      (arst),
      .addr_o    (rd_addr_wclk)
   );

   // Fill levels lag the far pointer, good enough for flow control only
   always_ff @(posedge wclk or posedge arst) begin
      if (arst) begin
         level_wclk_o <= '0;
      end else begin
         level_wclk_o <= wr_addr - rd_addr_wclk;
      end
   end

   always_ff @(posedge rclk or posedge arst) begin
      if (arst) begin
         level_rclk_o <= '0;
      end else begin
         level_rclk_o <= wr_addr_rclk - rd_addr;
      end
   end

endmodule

/* verilog/frame_sum_stage.sv */
`timescale 1ns/1ps

module frame_sum_stage (
   input  logic                       rclk,
   input  logic                       arst,
   input  cdc_pkg::fifo_word_t        rd_word_i,
   input  logic                       rd_valid_i,
   output logic                       rd_ready_o,
   output logic                       out_valid_o,
   output logic [cdc_pkg::DATA_W-1:0] out_data_o,
   output logic                       out_last_o,
   output logic [cdc_pkg::DATA_W-1:0] out_sum_o,
   input  logic                       out_ready_i
);

   import cdc_pkg::*;

   fifo_word_t        out_q;
   logic [DATA_W-1:0] acc;
   logic [DATA_W-1:0] sum_q;
   logic              take;

   // Accept when the output register is empty or being drained this cycle
   assign rd_ready_o = ~out_valid_o | out_ready_i;
   assign take       = rd_valid_i & rd_ready_o;

   always_ff @(posedge rclk or posedge arst) begin
      if (arst) begin
         out_valid_o <= 1'b0;
         acc         <= '0;
      end else begin
         if (take) begin
            out_valid_o <= 1'b1;
         end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
         end
         // Running XOR restarts after each frame end
         if (take) begin
            acc <= rd_word_i.last ? '0 : (acc ^ rd_word_i.data);
         end
      end
   end

   always_ff @(posedge rclk) begin
      if (take) begin
         out_q <= rd_word_i;
         if (rd_word_i.last) begin
            sum_q <= acc ^ rd_word_i.data;
         end
      end
   end

   assign out_data_o = out_q.data;
   assign out_last_o = out_q.last;
   assign out_sum_o  = sum_q;

endmodule

/* verilog/gray_send.sv */
`timescale 1ns/1ps

module gray_send #(
   parameter int WIDTH = 9
) (
   input  logic             clk_in_i,
   input  logic [WIDTH-1:0] addr_i,
   input  logic             clk_out_i,
   input  logic             arst,
   output logic [WIDTH-1:0] addr_o
);

   logic [WIDTH-1:0] gray_src;
   logic [WIDTH-1:0] gray_meta;
   logic [WIDTH-1:0] gray_sync;

   // Only one bit changes per increment, so the far side never sees a torn value
   always_ff @(posedge clk_in_i or posedge arst) begin
      if (arst) begin
         gray_src <= '0;
      end else begin
         gray_src <= addr_i ^ (addr_i >> 1);
      end
   end

   // Two-flop synchronizer in the destination domain
   always_ff @(posedge clk_out_i or posedge arst) begin
      if (arst) begin
         gray_meta <= '0;
         gray_sync <= '0;
      end else begin
         gray_meta <= gray_src;
         gray_sync <= gray_meta;
      end
   end

   // Gray back to binary, MSB first
   always_comb begin
      logic [WIDTH-1:0] bin;
      bin[WIDTH-1] = gray_sync[WIDTH-1];
      for (int i = WIDTH - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray_sync[i];
      end
      addr_o = bin;
   end

endmodule

/* verilog/ram_2port.sv */
`timescale 1ns/1ps

module ram_2port #(
   parameter int AWIDTH = 9
) (
   input  logic                   wclk,
   input  logic                   we_i,
   input  logic [AWIDTH-1:0]      waddr_i,
   input  cdc_pkg::fifo_word_t    wdata_i,
   input  logic                   rclk,
   input  logic                   re_i,
   input  logic [AWIDTH-1:0]      raddr_i,
   output cdc_pkg::fifo_word_t    rdata_o
);

   import cdc_pkg::*;

   fifo_word_t mem [2**AWIDTH];

   always_ff @(posedge wclk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // Output register only loads when enabled, so it can hold a prefetched word
   always_ff @(posedge rclk) begin
      if (re_i) begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule
